//--- design/boardPkg.sv
`default_nettype none

package boardPkg;

   ////////////////////////////////////////
   // Sizes and constants
   ////////////////////////////////////////

   localparam int wordBits = 32;
   localparam int numDigits = 8;
   localparam int digitIdxBits = $clog2(numDigits);

   // Three decades give the /10, /100 and /1000 ticks
   localparam int numStages = 3;
   localparam logic [3:0] decadeLast = 4'd9;

   // Centre button position inside the buttons field
   localparam int btnCentre = 0;

   // Every segment and the decimal point dark (active low)
   localparam logic [7:0] segBlank = 8'hFF;

   // Lit segment patterns with a at bit 0
   localparam logic [6:0] hexSeg [16] = '{
      7'h3F, 7'h06, 7'h5B, 7'h4F,
      7'h66, 7'h6D, 7'h7D, 7'h07,
      7'h7F, 7'h6F, 7'h77, 7'h7C,
      7'h39, 7'h5E, 7'h79, 7'h71
   };

   ////////////////////////////////////////
   // Grouped signals
   ////////////////////////////////////////

   // Buttons ordered centre, up, down, left and right from bit 0
   typedef struct packed {
      logic [15:0] switches;
      logic [4:0]  buttons;
   } boardInputs_t;

   typedef struct packed {
      logic [wordBits-1:0] portA;
      logic [wordBits-1:0] portB;
      logic [wordBits-1:0] portC;
      logic [wordBits-1:0] portD;
   } cpuPorts_t;

   typedef enum logic [3:0] {
      rateSlow   = 4'd0,
      rateMid    = 4'd1,
      rateFast   = 4'd2,
      rateFull   = 4'd3,
      rateManual = 4'd15
   } rateSel_t;

   // Codes above showButtons display zero
   typedef enum logic [3:0] {
      showPortA    = 4'd0,
      showPortB    = 4'd1,
      showPortC    = 4'd2,
      showPortD    = 4'd3,
      showCounter  = 4'd4,
      showSwitches = 4'd5,
      showButtons  = 4'd6
   } dispSel_t;

   // Every unlisted switch code means manual stepping
   function automatic rateSel_t decodeRate(input logic [3:0] code);
      rateSel_t rate;
      case (code)
         4'd0:    rate = rateSlow;
         4'd1:    rate = rateMid;
         4'd2:    rate = rateFast;
         4'd3:    rate = rateFull;
         default: rate = rateManual;
      endcase
      return rate;
   endfunction

endpackage

`default_nettype wire

//--- design/inputSampler.sv
`default_nettype none

module inputSampler
(
   input  logic                   f100Hz,
   input  logic                   res,
   input  boardPkg::boardInputs_t rawInputs,
   output boardPkg::boardInputs_t syncInputs,
   output logic                   stepPulse
);

   boardPkg::boardInputs_t metaInputs;
   logic centrePrev;
   logic centreNow;

   ////////////////////////////////////////
   // Two-flop synchronizer
   ////////////////////////////////////////

   always_ff @(posedge f100Hz or posedge res)
   begin
      if (res)
      begin
         metaInputs <= '0;
         syncInputs <= '0;
      end
      else
      begin
         metaInputs <= rawInputs;
         syncInputs <= metaInputs;
      end
   end

   ////////////////////////////////////////
   // Centre button edge
   ////////////////////////////////////////

   assign centreNow = syncInputs.buttons[boardPkg::btnCentre];

   // One cycle after the synchronized rise
   always_ff @(posedge f100Hz or posedge res)
   begin
      if (res)
      begin
         centrePrev <= 1'b0;
         stepPulse  <= 1'b0;
      end
      else
      begin
         centrePrev <= centreNow;
         stepPulse  <= centreNow & ~centrePrev;
      end
   end

endmodule

`default_nettype wire

//--- design/rateStepper.sv
`default_nettype none

module rateStepper
(
   input  logic                          f100Hz,
   input  logic                          res,
   input  boardPkg::rateSel_t            rate,
   input  logic                          stepPulse,
   output logic [boardPkg::wordBits-1:0] testCount
);

   logic [3:0] decCnt [boardPkg::numStages];

   // carry[i] is the tick for divide by 10**i
   logic [boardPkg::numStages:0] carry;
   logic stepNow;

   ////////////////////////////////////////
   // Decade prescaler
   ////////////////////////////////////////

   always_comb
   begin
      // Full rate never waits
      carry[0] = 1'b1;
      for (int i = 0; i < boardPkg::numStages; i++)
      begin
         carry[i+1] = carry[i] && (decCnt[i] == boardPkg::decadeLast);
      end
   end

   // Free running, so the phase after a rate change is arbitrary
   always_ff @(posedge f100Hz or posedge res)
   begin
      if (res)
      begin
         for (int i = 0; i < boardPkg::numStages; i++)
         begin
            decCnt[i] <= 4'd0;
         end
      end
      else
      begin
         for (int i = 0; i < boardPkg::numStages; i++)
         begin
            if (carry[i])
            begin
               if (decCnt[i] == boardPkg::decadeLast)
                  decCnt[i] <= 4'd0;
               else
                  decCnt[i] <= decCnt[i] + 4'd1;
            end
         end
      end
   end

   ////////////////////////////////////////
   // Step select and test counter
   ////////////////////////////////////////

   always_comb
   begin
      case (rate)
         boardPkg::rateFull: stepNow = carry[0];
         boardPkg::rateFast: stepNow = carry[1];
         boardPkg::rateMid:  stepNow = carry[2];
         boardPkg::rateSlow: stepNow = carry[3];
         // Only the button moves the count in manual mode
         default:            stepNow = stepPulse;
      endcase
   end

   always_ff @(posedge f100Hz or posedge res)
   begin
      if (res)
         testCount <= '0;
      else if (stepNow)
         testCount <= testCount + 1'b1;
   end

endmodule

`default_nettype wire

//--- design/displaySelect.sv
`default_nettype none

module displaySelect
(
   input  logic                          f100Hz,
   input  logic                          res,
   input  boardPkg::dispSel_t            sel,
   input  boardPkg::cpuPorts_t           cpuPorts,
   input  logic [boardPkg::wordBits-1:0] testCount,
   input  boardPkg::boardInputs_t        syncInputs,
   output logic [boardPkg::wordBits-1:0] dispWord
);

   logic [boardPkg::wordBits-1:0] wordNext;

   // Source mux
   always_comb
   begin
      wordNext = '0;
      case (sel)
         boardPkg::showPortA:   wordNext = cpuPorts.portA;
         boardPkg::showPortB:   wordNext = cpuPorts.portB;
         boardPkg::showPortC:   wordNext = cpuPorts.portC;
         boardPkg::showPortD:   wordNext = cpuPorts.portD;
         boardPkg::showCounter: wordNext = testCount;
         boardPkg::showSwitches:
         begin
            wordNext[$bits(syncInputs.switches)-1:0] = syncInputs.switches;
         end
         boardPkg::showButtons:
         begin
            wordNext[$bits(syncInputs.buttons)-1:0] = syncInputs.buttons;
         end
         // Unused codes stay blank as zero
         default:               wordNext = '0;
      endcase
   end

   // Held steady for the scanner
   always_ff @(posedge f100Hz or posedge res)
   begin
      if (res)
         dispWord <= '0;
      else
         dispWord <= wordNext;
   end

endmodule

`default_nettype wire

//--- design/segScanner.sv
`default_nettype none

module segScanner
(
   input  logic                           f100Hz,
   input  logic                           res,
   input  logic [boardPkg::wordBits-1:0]  dispWord,
   output logic [7:0]                     seg,
   output logic [boardPkg::numDigits-1:0] an
);

   logic [boardPkg::digitIdxBits-1:0] digitIdx;
   logic [3:0] nibble;
   logic [7:0] segNext;
   logic [boardPkg::numDigits-1:0] anNext;

   ////////////////////////////////////////
   // Digit decode
   ////////////////////////////////////////

   // Nibble k goes to digit k
   assign nibble = dispWord[{digitIdx, 2'b00} +: 4];

   // Decimal point stays dark
   assign segNext = {1'b1, ~boardPkg::hexSeg[nibble]};

   always_comb
   begin
      anNext = '1;
      anNext[digitIdx] = 1'b0;
   end

   ////////////////////////////////////////
   // Scan registers
   ////////////////////////////////////////

   always_ff @(posedge f100Hz or posedge res)
   begin
      if (res)
      begin
         digitIdx <= '0;
      end
      else
      begin
         if (int'(digitIdx) == boardPkg::numDigits - 1)
            digitIdx <= '0;
         else
            digitIdx <= digitIdx + 1'b1;
      end
   end

   // Segments and enable leave together so they never skew
   always_ff @(posedge f100Hz or posedge res)
   begin
      if (res)
      begin
         seg <= boardPkg::segBlank;
         an  <= '1;
      end
      else
      begin
         seg <= segNext;
         an  <= anNext;
      end
   end

endmodule

`default_nettype wire

//--- design/boardTest.sv
`default_nettype none

module boardTest
(
   input  logic                           f100Hz,
   input  logic                           res,
   input  boardPkg::boardInputs_t         rawInputs,
   input  boardPkg::cpuPorts_t            cpuPorts,
   output logic [7:0]                     seg,
   output logic [boardPkg::numDigits-1:0] an
);

   boardPkg::boardInputs_t syncInputs;
   logic stepPulse;
   boardPkg::rateSel_t rate;
   boardPkg::dispSel_t sel;
   logic [boardPkg::wordBits-1:0] testCount;
   logic [boardPkg::wordBits-1:0] dispWord;

   // Rate field on switches 15..12 and display field on 7..4
   assign rate = boardPkg::decodeRate(syncInputs.switches[15:12]);
   assign sel  = boardPkg::dispSel_t'(syncInputs.switches[7:4]);

   ////////////////////////////////////////
   // Pipeline stages
   ////////////////////////////////////////

   inputSampler sampler
   (
      .f100Hz     (f100Hz),
      .res        (res),
      .rawInputs  (rawInputs),
      .syncInputs (syncInputs),
      .stepPulse  (stepPulse)
   );

   rateStepper stepper
   (
      .f100Hz    (f100Hz),
      .res       (res),
      .rate      (rate),
      .stepPulse (stepPulse),
      .testCount (testCount)
   );

   displaySelect selector
   (
      .f100Hz     (f100Hz),
      .res        (res),
      .sel        (sel),
      .cpuPorts   (cpuPorts),
      .testCount  (testCount),
      .syncInputs (syncInputs),
      .dispWord   (dispWord)
   );

   segScanner scanner
   (
      .f100Hz   (f100Hz),
      .res      (res),
      .dispWord (dispWord),
      .seg      (seg),
      .an       (an)
   );

endmodule

`default_nettype wire

//--- sim/clockGen.sv
`default_nettype none

module clockGen
(
   output logic f100Hz,
   output logic res
);
   timeunit 1ns;
   timeprecision 1ps;

   // 100 ns period
   initial
   begin
      f100Hz = 1'b0;
      forever #50 f100Hz = ~f100Hz;
   end

   // Held for 4 rising edges and released on a falling edge
   initial
   begin
      res = 1'b1;
      repeat (4) @(posedge f100Hz);
      @(negedge f100Hz);
      res = 1'b0;
   end

endmodule

`default_nettype wire

//--- sim/boardChecker.sv
`default_nettype none

module boardChecker
(
   input  logic                           f100Hz,
   input  logic [7:0]                     seg,
   input  logic [boardPkg::numDigits-1:0] an,
   input  logic                           checkReq,
   input  logic [boardPkg::wordBits-1:0]  expMin,
   input  logic [boardPkg::wordBits-1:0]  expMax,
   output logic                           checkDone,
   output logic                           checkOk,
   output logic [boardPkg::wordBits-1:0]  shownWord
);
   timeunit 1ns;
   timeprecision 1ps;

   // Reverse lookup in the shared segment table
   function automatic logic decodeDigit(input logic [6:0] lit, output logic [3:0] value);
      logic found;
      found = 1'b0;
      value = 4'd0;
      for (int v = 0; v < 16; v++)
      begin
         if (boardPkg::hexSeg[v] == lit)
         begin
            found = 1'b1;
            value = 4'(v);
         end
      end
      return found;
   endfunction

   ////////////////////////////////////////
   // One full scan sampled mid-cycle
   ////////////////////////////////////////

   task automatic collectScan();
      logic [boardPkg::numDigits-1:0] seen;
      logic [boardPkg::wordBits-1:0] word;
      logic [3:0] nibble;
      logic undecodable;
      int pos;
      seen = '0;
      word = '0;
      undecodable = 1'b0;
      while (seen != '1)
      begin
         @(negedge f100Hz);
         if ($onehot(~an))
         begin
            pos = 0;
            for (int k = 0; k < boardPkg::numDigits; k++)
            begin
               if (!an[k])
                  pos = k;
            end
            if (!decodeDigit(~seg[6:0], nibble))
            begin
               undecodable = 1'b1;
               $display("Digit %0d shows segment pattern %h, which is no hex digit", pos, seg);
            end
            word[pos*4 +: 4] = nibble;
            seen[pos] = 1'b1;
         end
      end
      shownWord = word;
      checkOk = !undecodable && (word >= expMin) && (word <= expMax);
      if (!undecodable && !checkOk)
      begin
         if (expMin == expMax)
            $display("[ERROR] dispWord expected %h, got %h", expMin, word);
         else
            $display("[ERROR] dispWord expected %h to %h, got %h", expMin, expMax, word);
      end
      checkDone = 1'b1;
   endtask

   // Request seen on a rising edge and done cleared once it drops
   initial
   begin
      checkDone = 1'b0;
      checkOk = 1'b0;
      shownWord = '0;
      forever
      begin
         @(posedge f100Hz);
         if (!checkReq)
            checkDone = 1'b0;
         else if (!checkDone)
            collectScan();
      end
   end

endmodule

`default_nettype wire

//--- sim/boardTest_assert.sv
`default_nettype none

module boardTestAssert
(
   input logic                           f100Hz,
   input logic                           res,
   input logic [7:0]                     seg,
   input logic [boardPkg::numDigits-1:0] an,
   input boardPkg::rateSel_t             rate,
   input logic                           stepPulse,
   input logic [boardPkg::wordBits-1:0]  testCount
);
   timeunit 1ns;
   timeprecision 1ps;

   // All dark only in the first cycle out of reset
   anOneHot: assert property (@(posedge f100Hz) disable iff (res)
      $onehot(~an) || ($past(res) && an == '1))
      else $error("an is not one-hot low: %h", an);

   segPointOff: assert property (@(posedge f100Hz) disable iff (res) seg[7])
      else $error("decimal point segment is lit");

   countHolds: assert property (@(posedge f100Hz) disable iff (res)
      (rate == boardPkg::rateManual && !stepPulse) |=> $stable(testCount))
      else $error("testCount moved in manual mode without a step");

endmodule

bind boardTest boardTestAssert checks
(
   .f100Hz    (f100Hz),
   .res       (res),
   .seg       (seg),
   .an        (an),
   .rate      (rate),
   .stepPulse (stepPulse),
   .testCount (testCount)
);

`default_nettype wire

//--- sim/boardTestTb.sv
`default_nettype none

module boardTestTb;
   timeunit 1ns;
   timeprecision 1ps;

   typedef struct packed {
      boardPkg::boardInputs_t inputs;
      boardPkg::cpuPorts_t    ports;
      logic [15:0]            cycles;
      logic [7:0]             presses;
      logic [31:0]            expMin;
      logic [31:0]            expMax;
   } testRow_t;

   logic f100Hz;
   logic res;
   boardPkg::boardInputs_t rawInputs;
   boardPkg::cpuPorts_t cpuPorts;
   logic [7:0] seg;
   logic [boardPkg::numDigits-1:0] an;
   logic checkReq;
   logic [boardPkg::wordBits-1:0] expMin;
   logic [boardPkg::wordBits-1:0] expMax;
   logic checkDone;
   logic checkOk;
   logic [boardPkg::wordBits-1:0] shownWord;

   testRow_t rows[$];
   string rowNames[$];
   int cntLo;
   int cntHi;
   int passCount;
   int failCount;
   bit tableReady;

   clockGen clocks (.f100Hz(f100Hz), .res(res));

   boardTest dut
   (
      .f100Hz    (f100Hz),
      .res       (res),
      .rawInputs (rawInputs),
      .cpuPorts  (cpuPorts),
      .seg       (seg),
      .an        (an)
   );

   boardChecker monitor
   (
      .f100Hz    (f100Hz),
      .seg       (seg),
      .an        (an),
      .checkReq  (checkReq),
      .expMin    (expMin),
      .expMax    (expMax),
      .checkDone (checkDone),
      .checkOk   (checkOk),
      .shownWord (shownWord)
   );

   ////////////////////////////////////////
   // Stimulus table
   ////////////////////////////////////////

   // Counter bounds follow the step rules row by row
   task automatic addRow(input string name, input logic [3:0] sel, input logic [3:0] rate,
                         input int cycles, input int presses);
      testRow_t row;
      int div;
      logic [31:0] word;
      row.inputs.switches = {rate, 4'($urandom), sel, 4'($urandom)};
      // Centre stays low so only deliberate presses step the counter
      row.inputs.buttons = 5'($urandom) & 5'b11110;
      row.ports = {$urandom, $urandom, $urandom, $urandom};
      row.cycles = 16'(cycles);
      row.presses = 8'(presses);
      case (rate)
         4'd3:    div = 1;
         4'd2:    div = 10;
         4'd1:    div = 100;
         4'd0:    div = 1000;
         default: div = 0;
      endcase
      if (div == 0)
      begin
         cntLo += presses;
         cntHi += presses;
      end
      else
      begin
         cntHi += cycles / div + 1;
         if (cycles / div > 0)
            cntLo += cycles / div - 1;
      end
      case (sel)
         4'd0:    word = row.ports.portA;
         4'd1:    word = row.ports.portB;
         4'd2:    word = row.ports.portC;
         4'd3:    word = row.ports.portD;
         // Rate field reads manual while the scan is collected
         4'd5:    word = {16'd0, boardPkg::rateManual, row.inputs.switches[11:0]};
         4'd6:    word = {27'd0, row.inputs.buttons};
         default: word = 32'd0;
      endcase
      row.expMin = (sel == 4'd4) ? 32'(cntLo) : word;
      row.expMax = (sel == 4'd4) ? 32'(cntHi) : word;
      rows.push_back(row);
      rowNames.push_back(name);
   endtask

   task automatic buildTable();
      addRow("resetZero", boardPkg::showCounter, 4'hF, 0, 0);
      addRow("portA", boardPkg::showPortA, 4'hF, 20, 0);
      addRow("portB", boardPkg::showPortB, 4'h9, 20, 0);
      addRow("portC", boardPkg::showPortC, 4'hF, 20, 0);
      addRow("portD", boardPkg::showPortD, 4'h7, 20, 0);
      addRow("manualPress", boardPkg::showCounter, 4'hF, 0, 5);
      addRow("manualHold", boardPkg::showCounter, 4'hC, 300, 0);
      addRow("rateFull", boardPkg::showCounter, boardPkg::rateFull, 137, 0);
      addRow("rateFast", boardPkg::showCounter, boardPkg::rateFast, 455, 0);
      addRow("rateMid", boardPkg::showCounter, boardPkg::rateMid, 1230, 0);
      addRow("switches", boardPkg::showSwitches, 4'hF, 10, 0);
      addRow("buttons", boardPkg::showButtons, 4'hF, 10, 0);
      addRow("unusedCode", 4'd9, 4'hF, 10, 0);
      addRow("topCode", 4'd15, 4'hF, 10, 0);
   endtask

   task automatic pressCentre();
      rawInputs.buttons[boardPkg::btnCentre] = 1'b1;
      repeat (4) @(negedge f100Hz);
      rawInputs.buttons[boardPkg::btnCentre] = 1'b0;
      repeat (4) @(negedge f100Hz);
   endtask

   task automatic runCheck(input int idx);
      expMin = rows[idx].expMin;
      expMax = rows[idx].expMax;
      checkReq = 1'b1;
      do
      begin
         @(posedge f100Hz);
      end
      while (!checkDone);
      @(negedge f100Hz);
      checkReq = 1'b0;
      if (checkOk)
      begin
         passCount++;
         $display("%s: ok, dispWord %h", rowNames[idx], shownWord);
      end
      else
      begin
         failCount++;
         $display("%s: mismatch, dispWord %h", rowNames[idx], shownWord);
      end
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial
   begin
      // Manual rate with the counter selected from the start
      rawInputs = '0;
      rawInputs.switches = 16'hF040;
      cpuPorts = '0;
      checkReq = 1'b0;
      expMin = '0;
      expMax = '0;
      cntLo = 0;
      cntHi = 0;
      passCount = 0;
      failCount = 0;
      void'($urandom(60));
      buildTable();
      tableReady = 1'b1;
      wait (res == 1'b0);
      @(negedge f100Hz);
      for (int i = 0; i < rows.size(); i++)
      begin
         rawInputs = rows[i].inputs;
         cpuPorts = rows[i].ports;
         repeat (rows[i].presses) pressCentre();
         repeat (rows[i].cycles) @(negedge f100Hz);
         // Freeze the counter before looking at it
         rawInputs.switches[15:12] = boardPkg::rateManual;
         repeat (12) @(negedge f100Hz);
         runCheck(i);
      end
      $display("Summary: %0d passed, %0d failed", passCount, failCount);
      if (failCount == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

   // Watchdog sized from the table and doubled for margin
   initial
   begin
      longint limitNs;
      wait (tableReady);
      limitNs = 4;
      foreach (rows[i])
         limitNs += rows[i].cycles + 8 * rows[i].presses + 40;
      limitNs = limitNs * 100 * 2;
      #(limitNs);
      $display("Timeout: the run did not finish within %0d ns", limitNs);
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
design/boardPkg.sv
design/inputSampler.sv
design/rateStepper.sv
design/displaySelect.sv
design/segScanner.sv
design/boardTest.sv
sim/clockGen.sv
sim/boardChecker.sv
sim/boardTest_assert.sv
sim/boardTestTb.sv

//--- run.sh
#!/bin/sh
# Build and run the board test harness, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
   --top-module boardTestTb -f list.f -o boardTestSim > sim.log 2>&1 \
   && ./obj_dir/boardTestSim >> sim.log 2>&1 \
   || echo "Test failed" >> sim.log
if grep -q "Test failed" sim.log
then
   echo "FAIL (see sim.log)"
   exit 1
fi
echo "PASS"
exit 0
